// File: source/gcm_pkg.sv
`default_nettype none

package gcm_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// field and block geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int BLK_BITS = 128;    // data block, hash state, subkey

	// x^128 + x^7 + x^2 + x + 1 with the bit order reversed,
	// so bit 127 of a word is the x^0 coefficient
	localparam logic [BLK_BITS-1:0] GF_POLY = {8'he1, {(BLK_BITS-8){1'b0}}};

	localparam int GFM_CYCLES = 8;    // clocks per product, 16 bit steps each

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// message framing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int LEN_BITS = 64;     // each half of the length block
	localparam int CTR_BITS = 32;     // low counter field, wraps on its own

endpackage

`default_nettype wire

// File: source/gf128_mult.sv
`timescale 1ns/1ps
`default_nettype none

module gf128_mult #(
	parameter int CYCLES = gcm_pkg::GFM_CYCLES
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         start,
	input  logic [gcm_pkg::BLK_BITS-1:0] a,
	input  logic [gcm_pkg::BLK_BITS-1:0] b,
	output logic [gcm_pkg::BLK_BITS-1:0] result,
	output logic                         done
);
	import gcm_pkg::*;

	localparam int STEPS = BLK_BITS / CYCLES;     // bit steps per clock
	localparam int RND_W = $clog2(CYCLES + 1);

	logic                busy;
	logic [RND_W-1:0]    round;
	logic [BLK_BITS-1:0] op_v;        // multiplicand times x after each step
	logic [BLK_BITS-1:0] op_b;        // multiplier bits consumed msb first
	logic [BLK_BITS-1:0] acc_next;
	logic [BLK_BITS-1:0] v_next;
	logic [BLK_BITS-1:0] b_next;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// one clock worth of shift and reduce
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		acc_next = result;
		v_next = op_v;
		b_next = op_b;
		for (int i = 0; i < STEPS; i++) begin
			acc_next = acc_next ^ (b_next[BLK_BITS-1] ? v_next : '0);
			v_next = (v_next >> 1) ^ (v_next[0] ? GF_POLY : '0);    // reflected x * V
			b_next = b_next << 1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// round control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			round <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				round <= '0;
			end else if (busy) begin
				round <= round + 1'b1;
				if (round == RND_W'(CYCLES - 1)) begin
					done <= 1'b1;    // product lands with this edge
					busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			op_v <= a;
			op_b <= b;
			result <= '0;
		end else if (busy) begin
			op_v <= v_next;
			op_b <= b_next;
			result <= acc_next;
		end
	end

	// operands are only taken on start, so a product in flight must finish first
	a_no_restart: assert property (@(posedge clk) disable iff (reset)
		start |-> !busy)
		else $error("gf128_mult: start while a product is in progress");

endmodule

`default_nettype wire

// File: source/ctr_keystream.sv
`timescale 1ns/1ps
`default_nettype none

module ctr_keystream (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         init,
	input  logic [gcm_pkg::BLK_BITS-1:0] j0,
	input  logic                         blk_valid,
	input  logic                         blk_last,
	input  logic [gcm_pkg::BLK_BITS-1:0] blk_data,
	input  logic [gcm_pkg::BLK_BITS-1:0] cipher_out,
	input  logic                         cipher_done,
	output logic                         cipher_start,
	output logic [gcm_pkg::BLK_BITS-1:0] cipher_in,
	input  logic                         hash_idle,
	output logic                         ct_push,
	output logic                         ct_last,
	output logic [gcm_pkg::BLK_BITS-1:0] ct_word,
	output logic [gcm_pkg::BLK_BITS-1:0] ek_j0,
	output logic                         blk_ready
);
	import gcm_pkg::*;

	logic                req_j0;     // cipher busy with J0
	logic                req_blk;    // cipher busy with a counter block
	logic                ct_pend;    // ciphertext parked for the hash stage
	logic [BLK_BITS-1:0] ctr;        // next counter block
	logic [BLK_BITS-1:0] pt_reg;

	// increment only the low field, upper bits of the counter never change
	function automatic logic [BLK_BITS-1:0] inc32(input logic [BLK_BITS-1:0] cb);
		return {cb[BLK_BITS-1:CTR_BITS], cb[CTR_BITS-1:0] + CTR_BITS'(1)};
	endfunction

	assign ct_push = ct_pend & hash_idle;    // released as soon as GHASH is free

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request and hand-off control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			cipher_start <= 1'b0;
			req_j0 <= 1'b0;
			req_blk <= 1'b0;
			ct_pend <= 1'b0;
			blk_ready <= 1'b0;
		end else begin
			cipher_start <= 1'b0;
			if (init) begin
				cipher_start <= 1'b1;    // encrypt J0 for the tag
				req_j0 <= 1'b1;
				req_blk <= 1'b0;
				ct_pend <= 1'b0;
				blk_ready <= 1'b0;
			end else begin
				if (blk_valid) begin
					cipher_start <= 1'b1;
					req_blk <= 1'b1;
					blk_ready <= 1'b0;
				end
				if (cipher_done && req_j0) begin
					req_j0 <= 1'b0;
					blk_ready <= 1'b1;
				end
				if (cipher_done && req_blk) begin
					req_blk <= 1'b0;
					ct_pend <= 1'b1;
				end
				if (ct_push) begin
					ct_pend <= 1'b0;
					blk_ready <= !ct_last;    // message closed after last block
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// counter and data path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (init) begin
			cipher_in <= j0;
			ctr <= inc32(j0);    // first data counter is inc32(J0)
		end else if (blk_valid) begin
			cipher_in <= ctr;
			ctr <= inc32(ctr);
			pt_reg <= blk_data;
			ct_last <= blk_last;
		end
		if (cipher_done && req_j0) begin
			ek_j0 <= cipher_out;
		end
		if (cipher_done && req_blk) begin
			ct_word <= pt_reg ^ cipher_out;    // held until pushed
		end
	end

	a_blk_when_ready: assert property (@(posedge clk) disable iff (reset)
		blk_valid |-> blk_ready)
		else $error("ctr_keystream: blk_valid while blk_ready is low");

	a_done_matches_req: assert property (@(posedge clk) disable iff (reset)
		cipher_done |-> (req_j0 || req_blk))
		else $error("ctr_keystream: cipher_done with no request outstanding");

endmodule

`default_nettype wire

// File: source/ghash_accum.sv
`timescale 1ns/1ps
`default_nettype none

module ghash_accum (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         init,
	input  logic [gcm_pkg::BLK_BITS-1:0] h,
	input  logic                         ct_push,
	input  logic                         ct_last,
	input  logic [gcm_pkg::BLK_BITS-1:0] ct_word,
	input  logic [gcm_pkg::BLK_BITS-1:0] ek_j0,
	output logic                         hash_idle,
	output logic                         mul_start,
	output logic [gcm_pkg::BLK_BITS-1:0] mul_a,
	output logic [gcm_pkg::BLK_BITS-1:0] mul_b,
	input  logic [gcm_pkg::BLK_BITS-1:0] mul_result,
	input  logic                         mul_done,
	output logic                         tag_valid,
	output logic [gcm_pkg::BLK_BITS-1:0] tag
);
	import gcm_pkg::*;

	localparam int BLK_SHIFT = $clog2(BLK_BITS);        // blocks to bits
	localparam int CNT_BITS = LEN_BITS - BLK_SHIFT;

	logic [BLK_BITS-1:0] acc;          // running hash Y
	logic [BLK_BITS-1:0] h_reg;
	logic [CNT_BITS-1:0] blk_cnt;
	logic                last_pend;    // product in flight is the last data block
	logic                len_busy;     // product in flight is the length block
	logic [BLK_BITS-1:0] len_blk;

	assign mul_b = h_reg;

	// AAD length is always zero, text length is count * 128
	assign len_blk = {{LEN_BITS{1'b0}}, blk_cnt, {BLK_SHIFT{1'b0}}};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			hash_idle <= 1'b1;
			mul_start <= 1'b0;
			tag_valid <= 1'b0;
			last_pend <= 1'b0;
			len_busy <= 1'b0;
			blk_cnt <= '0;
		end else begin
			mul_start <= 1'b0;
			tag_valid <= 1'b0;
			if (init) begin
				hash_idle <= 1'b1;
				last_pend <= 1'b0;
				len_busy <= 1'b0;
				blk_cnt <= '0;
			end else if (ct_push) begin
				mul_start <= 1'b1;
				hash_idle <= 1'b0;
				last_pend <= ct_last;
				blk_cnt <= blk_cnt + 1'b1;
			end else if (mul_done) begin
				if (len_busy) begin
					len_busy <= 1'b0;
					tag_valid <= 1'b1;
				end else begin
					hash_idle <= 1'b1;
					if (last_pend) begin
						mul_start <= 1'b1;    // length block straight away
						len_busy <= 1'b1;
						last_pend <= 1'b0;
					end
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// hash state and operands
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (init) begin
			acc <= '0;
			h_reg <= h;
		end else if (ct_push) begin
			mul_a <= acc ^ ct_word;
		end else if (mul_done) begin
			acc <= mul_result;
			if (len_busy) begin
				tag <= mul_result ^ ek_j0;
			end else if (last_pend) begin
				mul_a <= mul_result ^ len_blk;
			end
		end
	end

	// the counter stage must hold its ciphertext while a product runs
	a_push_when_idle: assert property (@(posedge clk) disable iff (reset)
		ct_push |-> hash_idle)
		else $error("ghash_accum: ct_push while the hash stage is busy");

endmodule

`default_nettype wire

// File: source/gcm_core.sv
`timescale 1ns/1ps
`default_nettype none

module gcm_core (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         init,
	input  logic [gcm_pkg::BLK_BITS-1:0] j0,
	input  logic [gcm_pkg::BLK_BITS-1:0] h,
	input  logic                         blk_valid,
	input  logic [gcm_pkg::BLK_BITS-1:0] blk_data,
	input  logic                         blk_last,
	output logic                         blk_ready,
	output logic                         cipher_start,
	output logic [gcm_pkg::BLK_BITS-1:0] cipher_in,
	input  logic [gcm_pkg::BLK_BITS-1:0] cipher_out,
	input  logic                         cipher_done,
	output logic                         ct_valid,
	output logic [gcm_pkg::BLK_BITS-1:0] ct_data,
	output logic                         tag_valid,
	output logic [gcm_pkg::BLK_BITS-1:0] tag
);
	import gcm_pkg::*;

	logic                ct_push;       // counter stage to hash stage
	logic                ct_last;
	logic [BLK_BITS-1:0] ct_word;
	logic [BLK_BITS-1:0] ek_j0;
	logic                hash_idle;
	logic                mul_start;     // hash stage to multiplier
	logic [BLK_BITS-1:0] mul_a;
	logic [BLK_BITS-1:0] mul_b;
	logic [BLK_BITS-1:0] mul_result;
	logic                mul_done;

	assign ct_valid = ct_push;    // ciphertext leaves as it enters GHASH
	assign ct_data = ct_word;

	ctr_keystream u_ctr (
		.clk          (clk),
		.reset        (reset),
		.init         (init),
		.j0           (j0),
		.blk_valid    (blk_valid),
		.blk_last     (blk_last),
		.blk_data     (blk_data),
		.cipher_out   (cipher_out),
		.cipher_done  (cipher_done),
		.cipher_start (cipher_start),
		.cipher_in    (cipher_in),
		.hash_idle    (hash_idle),
		.ct_push      (ct_push),
		.ct_last      (ct_last),
		.ct_word      (ct_word),
		.ek_j0        (ek_j0),
		.blk_ready    (blk_ready)
	);

	ghash_accum u_ghash (
		.clk        (clk),
		.reset      (reset),
		.init       (init),
		.h          (h),
		.ct_push    (ct_push),
		.ct_last    (ct_last),
		.ct_word    (ct_word),
		.ek_j0      (ek_j0),
		.hash_idle  (hash_idle),
		.mul_start  (mul_start),
		.mul_a      (mul_a),
		.mul_b      (mul_b),
		.mul_result (mul_result),
		.mul_done   (mul_done),
		.tag_valid  (tag_valid),
		.tag        (tag)
	);

	gf128_mult #(
		.CYCLES (GFM_CYCLES)
	) u_mult (
		.clk    (clk),
		.reset  (reset),
		.start  (mul_start),
		.a      (mul_a),
		.b      (mul_b),
		.result (mul_result),
		.done   (mul_done)
	);

endmodule

`default_nettype wire

// File: sim/gcm_checker.sv
`timescale 1ns/1ps
`default_nettype none

module gcm_checker #(
	parameter logic [gcm_pkg::BLK_BITS-1:0] KEY = '0,
	parameter int EXP_CT = 0,
	parameter int EXP_TAG = 0
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         init,
	input  logic [gcm_pkg::BLK_BITS-1:0] j0,
	input  logic [gcm_pkg::BLK_BITS-1:0] h,
	input  logic                         blk_valid,
	input  logic [gcm_pkg::BLK_BITS-1:0] blk_data,
	input  logic                         blk_ready,
	input  logic                         cipher_start,
	input  logic                         ct_valid,
	input  logic [gcm_pkg::BLK_BITS-1:0] ct_data,
	input  logic                         tag_valid,
	input  logic [gcm_pkg::BLK_BITS-1:0] tag,
	input  logic                         run_done,
	output int                           err_count,
	output int                           ct_count,
	output int                           tag_count
);
	import gcm_pkg::*;

	logic [BLK_BITS-1:0] exp_q [$];    // predicted ciphertexts in input order
	logic [BLK_BITS-1:0] ctr_m;
	logic [BLK_BITS-1:0] h_m;
	logic [BLK_BITS-1:0] ekj0_m;
	logic [BLK_BITS-1:0] y_m;          // model hash state
	logic [BLK_BITS-1:0] prev_exp_tag;
	logic [BLK_BITS-1:0] prev_tag;
	logic                have_prev;
	logic                rst_d = 1'b0;
	logic                reported;
	int                  nblk;
	int                  msg_idx;
	int                  msg_err;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [BLK_BITS-1:0] cipher_model(input logic [BLK_BITS-1:0] x);
		return KEY ^ {x[BLK_BITS-14:0], x[BLK_BITS-1:BLK_BITS-13]};    // rotl 13
	endfunction

	function automatic logic [BLK_BITS-1:0] counter_step(input logic [BLK_BITS-1:0] cb);
		logic [CTR_BITS-1:0] low;
		low = cb[CTR_BITS-1:0] + 1'b1;
		return {cb[BLK_BITS-1:CTR_BITS], low};
	endfunction

	// GCM spec multiply taking one bit of x at a time from the x^0 end
	function automatic logic [BLK_BITS-1:0] gf_product(input logic [BLK_BITS-1:0] x,
			input logic [BLK_BITS-1:0] y);
		logic [BLK_BITS-1:0] z;
		logic [BLK_BITS-1:0] v;
		z = '0;
		v = y;
		for (int i = 0; i < BLK_BITS; i++) begin
			if (x[BLK_BITS-1-i])
				z = z ^ v;
			v = v[0] ? ((v >> 1) ^ GF_POLY) : (v >> 1);
		end
		return z;
	endfunction

	always @(posedge clk) begin : compare_proc
		logic [BLK_BITS-1:0] e;
		logic [BLK_BITS-1:0] exp_tag;
		if (reset) begin
			err_count = 0;
			ct_count = 0;
			tag_count = 0;
			msg_idx = 0;
			have_prev = 1'b0;
			reported = 1'b0;
			exp_q.delete();
		end else begin
			if (rst_d && (ct_valid !== 1'b0 || tag_valid !== 1'b0 ||
					cipher_start !== 1'b0 || blk_ready !== 1'b0)) begin
				$display("ERROR at %0t: outputs not idle right after reset", $time);
				err_count++;
			end
			if (init) begin
				ctr_m = counter_step(j0);
				h_m = h;
				ekj0_m = cipher_model(j0);
				y_m = '0;
				nblk = 0;
				msg_err = 0;
				exp_q.delete();
			end
			if (blk_valid) begin
				exp_q.push_back(blk_data ^ cipher_model(ctr_m));
				ctr_m = counter_step(ctr_m);
			end
			if (ct_valid) begin
				ct_count++;
				if (exp_q.size() == 0) begin
					$display("a ciphertext came out at %0t with no block waiting for it", $time);
					err_count++;
					msg_err++;
				end else begin
					e = exp_q.pop_front();
					if (ct_data !== e) begin
						$display("ERROR at %0t: msg %0d blk %0d ct %h, expected %h",
							$time, msg_idx, nblk, ct_data, e);
						err_count++;
						msg_err++;
					end
					y_m = gf_product(y_m ^ e, h_m);
					nblk++;
				end
			end
			if (tag_valid) begin
				tag_count++;
				exp_tag = gf_product(y_m ^ {{LEN_BITS{1'b0}}, LEN_BITS'(nblk * BLK_BITS)}, h_m);
				exp_tag = exp_tag ^ ekj0_m;
				if (exp_q.size() != 0) begin
					$display("the tag came with %0d ciphertexts never delivered", exp_q.size());
					err_count++;
					msg_err++;
				end
				if (tag !== exp_tag) begin
					$display("ERROR at %0t: msg %0d tag %h, expected %h",
						$time, msg_idx, tag, exp_tag);
					err_count++;
					msg_err++;
				end
				if (have_prev && exp_tag == prev_exp_tag && tag !== prev_tag) begin
					$display("ERROR at %0t: msg %0d tag differs from the same message before",
						$time, msg_idx);
					err_count++;
					msg_err++;
				end
				prev_exp_tag = exp_tag;
				prev_tag = tag;
				have_prev = 1'b1;
				$display("message %0d: %0d blocks, %0d errors", msg_idx, nblk, msg_err);
				msg_idx++;
			end
			if (run_done && !reported) begin
				reported = 1'b1;
				if (ct_count != EXP_CT || tag_count != EXP_TAG) begin
					$display("expected %0d ciphertexts and %0d tags but saw a different number",
						EXP_CT, EXP_TAG);
					err_count++;
				end
				$display("totals: %0d messages, %0d ciphertexts, %0d tags, %0d errors",
					msg_idx, ct_count, tag_count, err_count);
			end
		end
		rst_d = reset;
	end

endmodule

`default_nettype wire

// File: sim/gcm_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gcm_core_tb;
	import gcm_pkg::*;

	localparam int NUM_MSG = 5;
	localparam int MAX_BLK = 8;
	localparam logic [BLK_BITS-1:0] CIPHER_KEY = 128'h2b7e151628aed2a6abf7158809cf4f3c;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus table, one row per message
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam logic [BLK_BITS-1:0] TBL_J0 [NUM_MSG] = '{
		128'hcafebabefacedbaddecaf888_00000001,
		128'hcafebabefacedbaddecaf888_00000001,    // same as row 0
		128'h000102030405060708090a0b_ffffffff,    // counter wraps
		128'h9313225df88406e555909c5a_00000001,
		128'hfeedfacedeadbeeffeedface_7ffffffd
	};
	localparam logic [BLK_BITS-1:0] TBL_H [NUM_MSG] = '{
		128'h66e94bd4ef8a2c3b884cfa59ca342b2e,
		128'h66e94bd4ef8a2c3b884cfa59ca342b2e,
		128'hb83b533708bf535d0aa6e52980d53b78,
		128'hacbef20579b4b8ebce889bac8732dad7,
		128'h0388dace60b6a392f328c2b971b2fe78
	};
	localparam int TBL_BLOCKS [NUM_MSG] = '{4, 4, 3, 1, 6};
	localparam bit TBL_REPLAY [NUM_MSG] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0};    // reuse plaintext

	function automatic int sum_blocks();
		int s;
		s = 0;
		for (int i = 0; i < NUM_MSG; i++)
			s += TBL_BLOCKS[i];
		return s;
	endfunction

	localparam int TOTAL_BLOCKS = sum_blocks();
	localparam int TIMEOUT_CYCLES = (TOTAL_BLOCKS + 2 * NUM_MSG) * (12 + GFM_CYCLES + 6) + 50;

	logic                clk;
	logic                reset;
	logic                init;
	logic [BLK_BITS-1:0] j0;
	logic [BLK_BITS-1:0] h;
	logic                blk_valid;
	logic [BLK_BITS-1:0] blk_data;
	logic                blk_last;
	logic                blk_ready;
	logic                cipher_start;
	logic [BLK_BITS-1:0] cipher_in;
	logic [BLK_BITS-1:0] cipher_out;
	logic                cipher_done;
	logic                ct_valid;
	logic [BLK_BITS-1:0] ct_data;
	logic                tag_valid;
	logic [BLK_BITS-1:0] tag;
	logic                run_done;
	int                  err_count;
	int                  ct_count;
	int                  tag_count;
	int                  cycle_cnt = 0;
	logic [15:0]         lfsr;
	logic [BLK_BITS-1:0] prev_pt [MAX_BLK];

	gcm_core UUT (
		.clk(clk), .reset(reset), .init(init), .j0(j0), .h(h),
		.blk_valid(blk_valid), .blk_data(blk_data), .blk_last(blk_last), .blk_ready(blk_ready),
		.cipher_start(cipher_start), .cipher_in(cipher_in),
		.cipher_out(cipher_out), .cipher_done(cipher_done),
		.ct_valid(ct_valid), .ct_data(ct_data), .tag_valid(tag_valid), .tag(tag)
	);

	gcm_checker #(.KEY(CIPHER_KEY), .EXP_CT(TOTAL_BLOCKS), .EXP_TAG(NUM_MSG)) u_checker (
		.clk(clk), .reset(reset), .init(init), .j0(j0), .h(h),
		.blk_valid(blk_valid), .blk_data(blk_data), .blk_ready(blk_ready),
		.cipher_start(cipher_start), .ct_valid(ct_valid), .ct_data(ct_data),
		.tag_valid(tag_valid), .tag(tag), .run_done(run_done),
		.err_count(err_count), .ct_count(ct_count), .tag_count(tag_count)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_bits(input int n, output logic [BLK_BITS-1:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = {val[BLK_BITS-2:0], lfsr[0]};
		end
	endtask

	task automatic wait_ready();
		do @(posedge clk); while (!blk_ready);
		#1;
	endtask

	task automatic wait_tag();
		do @(posedge clk); while (!tag_valid);
	endtask

	// stand-in block cipher with random latency
	initial begin
		logic [BLK_BITS-1:0] req;
		logic [BLK_BITS-1:0] draw;
		int delay;
		cipher_done = 1'b0;
		cipher_out = '0;
		forever begin
			@(posedge clk);
			if (cipher_start === 1'b1) begin
				req = cipher_in;
				draw_bits(4, draw);
				delay = int'(draw[3:0]) % 12 + 1;    // 1 to 12 cycles
				repeat (delay - 1) @(posedge clk);
				#1;
				cipher_done = 1'b1;
				cipher_out = CIPHER_KEY ^ {req[BLK_BITS-14:0], req[BLK_BITS-1:BLK_BITS-13]};
				@(posedge clk);
				#1;
				cipher_done = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles waiting on the DUT", cycle_cnt);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial begin
		logic [BLK_BITS-1:0] pt;
		reset = 1'b1;
		init = 1'b0;
		j0 = '0;
		h = '0;
		blk_valid = 1'b0;
		blk_data = '0;
		blk_last = 1'b0;
		run_done = 1'b0;
		lfsr = 16'd43992;
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;
		for (int m = 0; m < NUM_MSG; m++) begin
			@(posedge clk);
			#1;
			init = 1'b1;
			j0 = TBL_J0[m];
			h = TBL_H[m];
			@(posedge clk);
			#1;
			init = 1'b0;
			for (int b = 0; b < TBL_BLOCKS[m]; b++) begin
				wait_ready();
				if (TBL_REPLAY[m])
					pt = prev_pt[b];
				else
					draw_bits(BLK_BITS, pt);
				prev_pt[b] = pt;
				blk_valid = 1'b1;
				blk_data = pt;
				blk_last = (b == TBL_BLOCKS[m] - 1);
				@(posedge clk);
				#1;
				blk_valid = 1'b0;
				blk_last = 1'b0;
			end
			wait_tag();
		end
		@(posedge clk);
		#1 run_done = 1'b1;    // checker closes its counts
		@(posedge clk);
		#1;
		if (err_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: gcm_core.f
source/gcm_pkg.sv
source/gf128_mult.sv
source/ctr_keystream.sv
source/ghash_accum.sv
source/gcm_core.sv
sim/gcm_checker.sv
sim/gcm_core_tb.sv

// File: Makefile
# Verilator flow for the GCM datapath

TOP = gcm_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module gcm_core -f gcm_core.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f gcm_core.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
